//--- design/vp_macros.svh
`ifndef VP_MACROS_SVH
`define VP_MACROS_SVH

// ------------------------------
// Clock enable dividers
// ------------------------------

// Counter width of both strobe dividers
`define VP_DIV_W 4

// CPU strobe, period 8 (NTSC) or 12 (PAL)
`define VP_CPU_LAST_NTSC 7
`define VP_CPU_LAST_PAL 11

// VDC strobe, period 6 (NTSC) or 10 (PAL)
`define VP_VDC_LAST_NTSC 5
`define VP_VDC_LAST_PAL 9

// ------------------------------
// Cartridge and character ROMs
// ------------------------------

// Cart sizes that enable bank bits 0 and 1
`define VP_BANK0_SIZE 4096
`define VP_BANK1_SIZE 8192

// Download slot numbers
`define VP_IDX_CART 1
`define VP_IDX_CHAR 2

// ROM address widths and size counter width
`define VP_CART_AW 14
`define VP_CHAR_AW 9
`define VP_SIZE_W 16

// ------------------------------
// Overscan trim
// ------------------------------

// Line blanked at or below first, at or above last
`define VP_TRIM_FIRST 46
`define VP_TRIM_LAST 367
`define VP_TRIM_W 16

`endif

//--- design/vp_pkg.sv
package vp_pkg;

	// One joystick word from the host, numpad in the top bits
	// Numpad bit 0 is key "1", bit 9 is key "0"
	typedef struct packed {
		logic [9:0] numpad;
		logic       reset;
		logic       action;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_word_t;

	// PS/2 event, toggle flips on every new code
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic [8:0] code;
	} ps2_key_t;

	// Host download bus
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
	} dl_t;

	// Cartridge request from the console
	typedef struct packed {
		logic [11:0] addr;
		logic        bank1;
		logic        bank0;
	} cart_req_t;

	// One-cycle enables for the console
	typedef struct packed {
		logic cpu;
		logic vdc;
	} clk_en_t;

	// Active-low joystick pins
	// Bit 1 joystick A, bit 0 joystick B
	typedef struct packed {
		logic [1:0] up;
		logic [1:0] down;
		logic [1:0] left;
		logic [1:0] right;
		logic [1:0] action;
	} joy_pins_t;

	// Key event towards the keyboard matrix
	typedef struct packed {
		logic       ready;
		logic       released;
		logic [7:0] ascii;
	} key_event_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb24_t;

	// Console colour, either as palette index or as pins
	typedef union packed {
		logic [3:0] index;
		struct packed {
			logic r;
			logic g;
			logic b;
			logic luma;
		} bits;
	} vp_color_u;

endpackage

//--- design/vp_clock_enables.sv
`timescale 1ns/1ps
`include "vp_macros.svh"

module vp_clock_enables
	import vp_pkg::*;
(
	input  logic    clk_sys,
	input  logic    reset,
	input  logic    pal_i,
	output clk_en_t clk_en_o
);

	localparam logic [`VP_DIV_W-1:0] CPU_LAST_NTSC = `VP_CPU_LAST_NTSC;
	localparam logic [`VP_DIV_W-1:0] CPU_LAST_PAL = `VP_CPU_LAST_PAL;
	localparam logic [`VP_DIV_W-1:0] VDC_LAST_NTSC = `VP_VDC_LAST_NTSC;
	localparam logic [`VP_DIV_W-1:0] VDC_LAST_PAL = `VP_VDC_LAST_PAL;

	logic [`VP_DIV_W-1:0] cpu_cnt;
	logic [`VP_DIV_W-1:0] vdc_cnt;
	logic [`VP_DIV_W-1:0] cpu_last;
	logic [`VP_DIV_W-1:0] vdc_last;
	logic                 cpu_stb;
	logic                 vdc_stb;

	// Terminal counts per video standard
	assign cpu_last = pal_i ? CPU_LAST_PAL : CPU_LAST_NTSC;
	assign vdc_last = pal_i ? VDC_LAST_PAL : VDC_LAST_NTSC;

	// ------------------------------
	// Wrap counters
	// ------------------------------

	// Strobe set on the wrap, so it is high one cycle per period
	// Greater-or-equal also recovers a count left above the last
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt <= '0;
			cpu_stb <= 1'b0;
			vdc_cnt <= '0;
			vdc_stb <= 1'b0;
		end else begin
			// CPU divider
			cpu_stb <= (cpu_cnt >= cpu_last);
			cpu_cnt <= (cpu_cnt >= cpu_last) ? '0 : cpu_cnt + 1'b1;
			// VDC divider, also the pixel enable
			vdc_stb <= (vdc_cnt >= vdc_last);
			vdc_cnt <= (vdc_cnt >= vdc_last) ? '0 : vdc_cnt + 1'b1;
		end
	end

	assign clk_en_o = '{cpu: cpu_stb, vdc: vdc_stb};

endmodule

//--- design/vp_input_router.sv
`timescale 1ns/1ps

module vp_input_router
	import vp_pkg::*;
(
	input  logic       joy_swap_i,
	input  joy_word_t  joystick_0_i,
	input  joy_word_t  joystick_1_i,
	output joy_pins_t  joy_pins_o,
	output logic       joy_reset_n_o,
	output logic [9:0] numpad_o
);

	joy_word_t joy_a;
	joy_word_t joy_b;

	// ------------------------------
	// Player select
	// ------------------------------

	// Swap puts host joystick 1 on console port A
	assign joy_a = joy_swap_i ? joystick_1_i : joystick_0_i;
	assign joy_b = joy_swap_i ? joystick_0_i : joystick_1_i;

	// ------------------------------
	// Console pins
	// ------------------------------

	// Pins pulled low when pressed
	// A in bit 1, B in bit 0
	assign joy_pins_o.up     = {~joy_a.up, ~joy_b.up};
	assign joy_pins_o.down   = {~joy_a.down, ~joy_b.down};
	assign joy_pins_o.left   = {~joy_a.left, ~joy_b.left};
	assign joy_pins_o.right  = {~joy_a.right, ~joy_b.right};
	assign joy_pins_o.action = {~joy_a.action, ~joy_b.action};

	// Reset button on either pad resets the console
	assign joy_reset_n_o = ~(joy_a.reset | joy_b.reset);

	// Number pads merged, no notion of player here
	assign numpad_o = joy_a.numpad | joy_b.numpad;

endmodule

//--- design/vp_key_translate.sv
`timescale 1ns/1ps

module vp_key_translate
	import vp_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  ps2_key_t   ps2_key_i,
	input  logic [9:0] numpad_i,
	output key_event_t key_event_o
);

	logic       toggle_q;
	logic [9:0] numpad_q;
	logic       ps2_chg;
	logic       pad_chg;
	logic       ps2_changed;
	logic       pad_changed;
	logic       released_q;
	logic [7:0] ps2_ascii;
	logic [7:0] pad_ascii;

	// ------------------------------
	// Translation tables
	// ------------------------------

	// Extended prefix bit is ignored, E0 codes share the base entry
	function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
		case (code)
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h45: return "0";
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			// GUI keys give the yes and no codes
			8'h1F: return 8'h11;
			8'h27: return 8'h12;
			8'h5A: return 8'h0A;
			8'h66: return 8'h08;
			default: return 8'h00;
		endcase
	endfunction

	// Lowest held key wins, bit 9 is key "0"
	function automatic logic [7:0] pad_to_ascii(input logic [9:0] pad);
		logic [7:0] ch;
		ch = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (pad[i]) ch = (i == 9) ? "0" : 8'(8'h31 + i);
		end
		return ch;
	endfunction

	// New code when the toggle flips, new pad state on any bit change
	assign ps2_chg = (ps2_key_i.toggle != toggle_q);
	assign pad_chg = |(numpad_i ^ numpad_q);

	// ------------------------------
	// Event registers
	// ------------------------------

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q    <= 1'b0;
			numpad_q    <= '0;
			ps2_changed <= 1'b0;
			pad_changed <= 1'b0;
			released_q  <= 1'b1;
			ps2_ascii   <= 8'h00;
			pad_ascii   <= 8'h00;
		end else begin
			toggle_q    <= ps2_key_i.toggle;
			numpad_q    <= numpad_i;
			ps2_changed <= ps2_chg;
			pad_changed <= pad_chg;
			// Key up only when neither source holds anything
			released_q  <= ~ps2_key_i.pressed & ~|numpad_i;
			if (ps2_chg)
				ps2_ascii <= scan_to_ascii(ps2_key_i.code[7:0]);
			if (pad_chg)
				pad_ascii <= pad_to_ascii(numpad_i);
		end
	end

	// Keyboard beats the pad when both change together
	assign key_event_o.ready    = ps2_changed | pad_changed;
	assign key_event_o.released = released_q;
	assign key_event_o.ascii    = ps2_changed ? ps2_ascii : pad_ascii;

endmodule

//--- design/vp_rom_port.sv
`timescale 1ns/1ps
`include "vp_macros.svh"

module vp_rom_port
	import vp_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  dl_t                    dl_i,
	input  cart_req_t              cart_req_i,
	input  logic [11:0]            char_addr_i,
	output logic [`VP_CART_AW-1:0] rom_addr_o,
	output logic                   rom_we_o,
	output logic [`VP_CHAR_AW-1:0] char_rom_addr_o,
	output logic                   char_we_o
);

	logic                  dl_q;
	logic [`VP_SIZE_W-1:0] cart_size;
	logic                  is_cart;
	logic                  is_char;
	logic                  bank1_en;
	logic                  bank0_en;

	assign is_cart = (dl_i.index == `VP_IDX_CART);
	assign is_char = (dl_i.index == `VP_IDX_CHAR);

	// ------------------------------
	// Cartridge size
	// ------------------------------

	// Cleared after download start, counts bytes written
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_q      <= 1'b0;
			cart_size <= '0;
		end else begin
			dl_q <= dl_i.download;
			if (dl_i.download & ~dl_q)
				cart_size <= '0;
			else if (dl_i.download & dl_i.wr)
				cart_size <= cart_size + 1'b1;
		end
	end

	// Bank bits only count once the image is large enough
	assign bank1_en = (cart_size >= `VP_BANK1_SIZE) & cart_req_i.bank1;
	assign bank0_en = (cart_size >= `VP_BANK0_SIZE) & cart_req_i.bank0;

	// Console A10 is not decoded by the cartridge
	assign rom_addr_o = (dl_i.download & is_cart) ? dl_i.addr[`VP_CART_AW-1:0] :
		{1'b0, bank1_en, bank0_en, cart_req_i.addr[11], cart_req_i.addr[9:0]};
	assign rom_we_o   = dl_i.wr & is_cart;

	// Char ROM only uses the low address bits
	assign char_rom_addr_o = (dl_i.download & is_char) ? dl_i.addr[`VP_CHAR_AW-1:0] :
		char_addr_i[`VP_CHAR_AW-1:0];
	assign char_we_o       = dl_i.wr & is_char;

endmodule

//--- design/vp_av_encode.sv
`timescale 1ns/1ps
`include "vp_macros.svh"

module vp_av_encode
	import vp_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        pal_i,
	input  logic        pix_en_i,
	input  vp_color_u   color_i,
	input  logic        hsync_n_i,
	input  logic        hblank_i,
	input  logic        trim_i,
	input  logic        wide_i,
	input  logic [3:0]  snd_i,
	output rgb24_t      rgb_o,
	output logic        hblank_o,
	output logic [15:0] audio_o,
	output logic [7:0]  video_arx_o,
	output logic [7:0]  video_ary_o
);

	// ------------------------------
	// Palettes
	// ------------------------------

	// Calibrated NTSC colours, by raw index
	localparam logic [23:0] NTSC_LUT [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};

	// PAL colours as two luma planes of eight hues
	// Hue is the r, g, b pin triple
	localparam logic [23:0] PAL_LUT [2][8] = '{
		'{24'h000000, 24'h0000b6, 24'h00b601, 24'h00b6c9,
		  24'hb60000, 24'hb600b6, 24'hb6b600, 24'hb6b6b6},
		'{24'h494949, 24'h4949ff, 24'h49ff49, 24'h49ffff,
		  24'hff4949, 24'hff49ff, 24'hffff49, 24'hffffff}
	};

	logic [2:0]            hue;
	logic                  hs_q;
	logic [`VP_TRIM_W-1:0] trim_cnt;

	assign hue   = {color_i.bits.r, color_i.bits.g, color_i.bits.b};
	assign rgb_o = pal_i ? PAL_LUT[color_i.bits.luma][hue] : NTSC_LUT[color_i.index];

	// ------------------------------
	// Overscan trim
	// ------------------------------

	// Pixel counter, sync sampled on pixel strobes only
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_q     <= 1'b1;
			trim_cnt <= '0;
		end else if (pix_en_i) begin
			hs_q     <= hsync_n_i;
			// Restart at the end of sync
			trim_cnt <= (~hs_q & hsync_n_i) ? '0 : trim_cnt + 1'b1;
		end
	end

	assign hblank_o = trim_i ?
		((trim_cnt <= `VP_TRIM_FIRST) || (trim_cnt >= `VP_TRIM_LAST)) : hblank_i;

	// ------------------------------
	// Audio and aspect
	// ------------------------------

	// Sound nibble stretched to 14 bits, centred for unsigned output
	assign audio_o = {2'b00, snd_i, snd_i, snd_i, snd_i[3:2]} + 16'h8000;

	assign video_arx_o = wide_i ? 8'd16 : 8'd4;
	assign video_ary_o = wide_i ? 8'd9 : 8'd3;

endmodule

//--- design/vp_host_glue.sv
`timescale 1ns/1ps
`include "vp_macros.svh"

module vp_host_glue
	import vp_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   pal_i,
	// Host inputs
	input  logic                   joy_swap_i,
	input  joy_word_t              joystick_0_i,
	input  joy_word_t              joystick_1_i,
	input  ps2_key_t               ps2_key_i,
	input  dl_t                    dl_i,
	// Console side
	input  cart_req_t              cart_req_i,
	input  logic [11:0]            char_addr_i,
	input  vp_color_u              color_i,
	input  logic                   hsync_n_i,
	input  logic                   hblank_i,
	input  logic [3:0]             snd_i,
	// Menu options
	input  logic                   trim_i,
	input  logic                   wide_i,
	output clk_en_t                clk_en_o,
	output joy_pins_t              joy_pins_o,
	output logic                   joy_reset_n_o,
	output key_event_t             key_event_o,
	output logic [`VP_CART_AW-1:0] rom_addr_o,
	output logic                   rom_we_o,
	output logic [`VP_CHAR_AW-1:0] char_rom_addr_o,
	output logic                   char_we_o,
	output rgb24_t                 rgb_o,
	output logic                   hblank_o,
	output logic [15:0]            audio_o,
	output logic [7:0]             video_arx_o,
	output logic [7:0]             video_ary_o
);

	// Merged number pad into the key translator
	logic [9:0] numpad;

	vp_clock_enables u_clock_enables (.clk_sys, .reset, .pal_i, .clk_en_o);

	vp_input_router u_input_router (.joy_swap_i, .joystick_0_i, .joystick_1_i,
		.joy_pins_o, .joy_reset_n_o, .numpad_o(numpad));

	vp_key_translate u_key_translate (.clk_sys, .reset, .ps2_key_i,
		.numpad_i(numpad), .key_event_o);

	vp_rom_port u_rom_port (.clk_sys, .reset, .dl_i, .cart_req_i, .char_addr_i,
		.rom_addr_o, .rom_we_o, .char_rom_addr_o, .char_we_o);

	// VDC strobe doubles as the pixel enable
	vp_av_encode u_av_encode (.clk_sys, .reset, .pal_i, .pix_en_i(clk_en_o.vdc),
		.color_i, .hsync_n_i, .hblank_i, .trim_i, .wide_i, .snd_i, .rgb_o,
		.hblank_o, .audio_o, .video_arx_o, .video_ary_o);

endmodule

//--- testbench/vp_host_glue_asserts.sv
`timescale 1ns/1ps

module vp_host_glue_asserts
	import vp_pkg::*;
(
	input logic       clk_sys,
	input logic       reset,
	input clk_en_t    clk_en_o,
	input key_event_t key_event_o
);

	// Failures seen, read back by the testbench at the end
	int fail_count = 0;

	// Strobes are single-cycle pulses
	cpu_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		clk_en_o.cpu |=> !clk_en_o.cpu)
		else begin
			$error("cpu strobe high for more than one cycle");
			fail_count++;
		end

	vdc_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		clk_en_o.vdc |=> !clk_en_o.vdc)
		else begin
			$error("vdc strobe high for more than one cycle");
			fail_count++;
		end

	// Nothing fires while reset is held
	quiet_in_reset: assert property (@(posedge clk_sys)
		reset |-> !clk_en_o.cpu && !clk_en_o.vdc && !key_event_o.ready)
		else begin
			$error("strobe or key ready high during reset");
			fail_count++;
		end

	// One ready pulse per key event
	ready_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		key_event_o.ready |=> !key_event_o.ready)
		else begin
			$error("key ready high for more than one cycle");
			fail_count++;
		end

endmodule

bind vp_host_glue vp_host_glue_asserts u_asserts (.clk_sys, .reset, .clk_en_o, .key_event_o);

//--- testbench/tb_vp_host_glue.sv
`timescale 1ns/1ps
`include "vp_macros.svh"

module tb_vp_host_glue;
	import vp_pkg::*;

	// ------------------------------
	// Run length
	// ------------------------------

	localparam int CLK_NS = 4;
	localparam int T1_CYC = 6 * 70;
	localparam int T2_CYC = 3 * 16500;
	localparam int T3_CYC = 24 * 2 + 4;
	localparam int T4_CYC = 20 + 6 * 4 + 4;
	localparam int T5_CYC = 32 + 2;
	localparam int T6_CYC = 3 * 3300 + 50;
	localparam int TEST_CYC = T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC + T6_CYC;
	localparam int WATCHDOG_NS = 2 * TEST_CYC * CLK_NS;

	// {scan code, ascii} pairs, PS/2 set 2
	localparam logic [15:0] KEY_TABLE [46] = '{
		16'h1631, 16'h1E32, 16'h2633, 16'h2534, 16'h2E35, 16'h3636, 16'h3D37, 16'h3E38,
		16'h4639, 16'h4530, 16'h1C61, 16'h3262, 16'h2163, 16'h2364, 16'h2465, 16'h2B66,
		16'h3467, 16'h3368, 16'h4369, 16'h3B6A, 16'h426B, 16'h4B6C, 16'h3A6D, 16'h316E,
		16'h446F, 16'h4D70, 16'h1571, 16'h2D72, 16'h1B73, 16'h2C74, 16'h3C75, 16'h2A76,
		16'h1D77, 16'h2278, 16'h3579, 16'h1A7A, 16'h2920, 16'h792B, 16'h7B2D, 16'h7C2A,
		16'h4A2F, 16'h553D, 16'h1F11, 16'h2712, 16'h5A0A, 16'h6608
	};

	// Palettes by raw index; PAL index is {hue, luma}
	localparam logic [23:0] NTSC_RGB [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6, 24'h006d07, 24'h56c469,
		24'h2aaabe, 24'h77e6eb, 24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};
	localparam logic [23:0] PAL_RGB [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff, 24'h00b601, 24'h49ff49,
		24'h00b6c9, 24'h49ffff, 24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	logic clk_sys;
	logic reset;
	logic pal_i, joy_swap_i, hsync_n_i, hblank_i, trim_i, wide_i;
	joy_word_t joystick_0_i, joystick_1_i;
	ps2_key_t ps2_key_i;
	dl_t dl_i;
	cart_req_t cart_req_i;
	logic [11:0] char_addr_i;
	vp_color_u color_i;
	logic [3:0] snd_i;
	clk_en_t clk_en_o;
	joy_pins_t joy_pins_o;
	logic joy_reset_n_o, rom_we_o, char_we_o, hblank_o;
	key_event_t key_event_o;
	logic [`VP_CART_AW-1:0] rom_addr_o;
	logic [`VP_CHAR_AW-1:0] char_rom_addr_o;
	rgb24_t rgb_o;
	logic [15:0] audio_o;
	logic [7:0] video_arx_o, video_ary_o;

	logic [31:0] lfsr_state = 32'h240e_406a;
	int checks = 0;
	int errors = 0;
	int tests_ok = 0;
	int test_start_errors;
	// Trim counter model
	logic model_hs;
	logic [15:0] model_cnt;

	vp_host_glue u_dut (.*);

	initial clk_sys = 1'b0;
	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	// Counter restarts on the first VDC strobe after hsync goes high
	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			model_hs  <= 1'b1;
			model_cnt <= '0;
		end else if (clk_en_o.vdc) begin
			model_hs  <= hsync_n_i;
			model_cnt <= (!model_hs && hsync_n_i) ? 16'd0 : model_cnt + 16'd1;
		end
	end

	// ------------------------------
	// Helpers
	// ------------------------------

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [7:0] expected_ascii(input logic [7:0] code);
		logic [7:0] ch;
		ch = 8'h00;
		foreach (KEY_TABLE[i])
			if (KEY_TABLE[i][15:8] == code) ch = KEY_TABLE[i][7:0];
		return ch;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] t=%0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Failure at t=%0t: %s", $time, what);
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic end_test(input string name);
		if (errors == test_start_errors) tests_ok++;
		$display("test %s: %s, %0d errors", name,
			(errors == test_start_errors) ? "ok" : "FAILED", errors - test_start_errors);
		test_start_errors = errors;
	endtask

	// Cartridge and char download of n writes at one index
	task automatic download(input logic [7:0] idx, input int n);
		logic [24:0] addr;
		next_cycle();
		dl_i = '{download: 1'b1, wr: 1'b0, index: idx, addr: '0};
		next_cycle();
		for (int k = 0; k < n; k++) begin
			addr = (idx == `VP_IDX_CART) ? 25'(k) : 25'(rand_bits(25));
			dl_i.wr = 1'b1;
			dl_i.addr = addr;
			#1;
			check_value("rom_we_o", idx == `VP_IDX_CART, rom_we_o);
			check_value("char_we_o", idx == `VP_IDX_CHAR, char_we_o);
			if (idx == `VP_IDX_CART)
				check_value("rom_addr_o", addr % (1 << `VP_CART_AW), rom_addr_o);
			else
				check_value("char_rom_addr_o", addr % (1 << `VP_CHAR_AW), char_rom_addr_o);
			next_cycle();
		end
		dl_i = '0;
	endtask

	// ------------------------------
	// Watchdog
	// ------------------------------

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("tests failed");
		$finish;
	end

	// ------------------------------
	// Test sequence
	// ------------------------------

	initial begin
		int last_cpu, last_vdc, n_cpu, n_vdc, n, size;
		int len;
		logic [7:0] code;
		logic pr;
		logic [9:0] pad, mask;
		joy_word_t ja, jb;
		logic [31:0] exp_addr;
		int low;

		reset = 1'b0;
		pal_i = 1'b0;
		joy_swap_i = 1'b0;
		joystick_0_i = '0;
		joystick_1_i = '0;
		ps2_key_i = '0;
		dl_i = '0;
		cart_req_i = '0;
		char_addr_i = '0;
		color_i = '0;
		hsync_n_i = 1'b1;
		hblank_i = 1'b0;
		trim_i = 1'b0;
		wide_i = 1'b0;
		snd_i = '0;
		test_start_errors = 0;
		// Reset rises after time zero, before the first clock edge
		#1;
		reset = 1'b1;
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		// Strobe periods per standard, each after a reset
		for (int t = 0; t < 6; t++) begin
			pal_i = rand_bits(1);
			reset = 1'b1;
			repeat (2) begin
				next_cycle();
				check_value("clk_en_o in reset", 0, clk_en_o);
			end
			reset = 1'b0;
			last_cpu = -1;
			last_vdc = -1;
			n_cpu = 0;
			n_vdc = 0;
			for (int c = 0; c < 64; c++) begin
				next_cycle();
				if (clk_en_o.cpu) begin
					if (last_cpu >= 0) check_value("cpu strobe gap", pal_i ? 12 : 8, c - last_cpu);
					last_cpu = c;
					n_cpu++;
				end
				if (clk_en_o.vdc) begin
					if (last_vdc >= 0) check_value("vdc strobe gap", pal_i ? 10 : 6, c - last_vdc);
					last_vdc = c;
					n_vdc++;
				end
			end
			if (n_cpu < 3 || n_vdc < 3) report_failure("too few strobes after reset");
		end
		end_test("strobe periods");

		// Char download, cart download, then bank-mapped requests
		for (int r = 0; r < 3; r++) begin
			download(`VP_IDX_CHAR, rand_bits(4) + 1);
			size = rand_bits(14);
			download(`VP_IDX_CART, size);
			for (int q = 0; q < 8; q++) begin
				cart_req_i = rand_bits(14);
				char_addr_i = rand_bits(12);
				#1;
				exp_addr = ((cart_req_i.bank1 && size >= `VP_BANK1_SIZE) << 12) |
					((cart_req_i.bank0 && size >= `VP_BANK0_SIZE) << 11) |
					(cart_req_i.addr[11] << 10) | cart_req_i.addr[9:0];
				check_value("rom_addr_o", exp_addr, rom_addr_o);
				check_value("rom_we_o", 0, rom_we_o);
				check_value("char_we_o", 0, char_we_o);
				check_value("char_rom_addr_o", char_addr_i % 512, char_rom_addr_o);
				next_cycle();
			end
		end
		end_test("cartridge mapping");

		// Table and unknown scan codes, one toggle flip each
		for (int t = 0; t < 24; t++) begin
			if (rand_bits(2) == 0)
				code = rand_bits(8);
			else
				code = KEY_TABLE[rand_bits(6) % 46][15:8];
			pr = rand_bits(1);
			ps2_key_i = '{toggle: ~ps2_key_i.toggle, pressed: pr, code: {1'b0, code}};
			next_cycle();
			check_value("key_event_o.ready", 1, key_event_o.ready);
			check_value("key_event_o.ascii", expected_ascii(code), key_event_o.ascii);
			check_value("key_event_o.released", !pr, key_event_o.released);
			next_cycle();
			check_value("key_event_o.ready", 0, key_event_o.ready);
		end
		ps2_key_i.pressed = 1'b0;
		next_cycle();
		end_test("key translation");

		// Pin vectors with the number pads idle
		for (int t = 0; t < 20; t++) begin
			joy_swap_i = rand_bits(1);
			joystick_0_i = rand_bits(6);
			joystick_1_i = rand_bits(6);
			#1;
			ja = joy_swap_i ? joystick_1_i : joystick_0_i;
			jb = joy_swap_i ? joystick_0_i : joystick_1_i;
			check_value("joy_pins_o.up", {~ja.up, ~jb.up}, joy_pins_o.up);
			check_value("joy_pins_o.down", {~ja.down, ~jb.down}, joy_pins_o.down);
			check_value("joy_pins_o.left", {~ja.left, ~jb.left}, joy_pins_o.left);
			check_value("joy_pins_o.right", {~ja.right, ~jb.right}, joy_pins_o.right);
			check_value("joy_pins_o.action", {~ja.action, ~jb.action}, joy_pins_o.action);
			check_value("joy_reset_n_o", !(ja.reset || jb.reset), joy_reset_n_o);
			next_cycle();
		end
		joystick_0_i = '0;
		joystick_1_i = '0;
		next_cycle();
		// Number pad split across both joysticks
		for (int t = 0; t < 6; t++) begin
			pad = rand_bits(10);
			if (pad == 0) pad = 10'h200;
			mask = rand_bits(10);
			joystick_0_i.numpad = pad & mask;
			joystick_1_i.numpad = pad & ~mask;
			low = 9;
			for (int i = 9; i >= 0; i--)
				if (pad[i]) low = i;
			next_cycle();
			check_value("key_event_o.ready", 1, key_event_o.ready);
			check_value("key_event_o.ascii", (low == 9) ? "0" : 8'h31 + low, key_event_o.ascii);
			check_value("key_event_o.released", 0, key_event_o.released);
			next_cycle();
			check_value("key_event_o.ready", 0, key_event_o.ready);
			joystick_0_i.numpad = '0;
			joystick_1_i.numpad = '0;
			next_cycle();
			check_value("key_event_o.ready", 1, key_event_o.ready);
			check_value("key_event_o.released", 1, key_event_o.released);
			next_cycle();
		end
		end_test("joystick routing");

		// Palette, audio word and aspect ratio
		for (int t = 0; t < 32; t++) begin
			color_i = rand_bits(4);
			pal_i = rand_bits(1);
			snd_i = rand_bits(4);
			wide_i = rand_bits(1);
			#1;
			check_value("rgb_o", pal_i ? PAL_RGB[color_i.index] : NTSC_RGB[color_i.index], rgb_o);
			check_value("audio_o", 32768 + (snd_i << 10) + (snd_i << 6) + (snd_i << 2) + (snd_i >> 2),
				audio_o);
			check_value("video_arx_o", wide_i ? 16 : 4, video_arx_o);
			check_value("video_ary_o", wide_i ? 9 : 3, video_ary_o);
			next_cycle();
		end
		end_test("palette and audio");

		// Trimmed lines of random length, then trim off
		pal_i = 1'b0;
		trim_i = 1'b1;
		for (int line = 0; line < 3; line++) begin
			n = 8 + rand_bits(2);
			// Every line runs past the upper trim limit
			len = n + 2240 + rand_bits(10);
			for (int c = 0; c < len; c++) begin
				hsync_n_i = (c >= n);
				hblank_i = rand_bits(1);
				#1;
				check_value("hblank_o", (model_cnt <= `VP_TRIM_FIRST) ||
					(model_cnt >= `VP_TRIM_LAST), hblank_o);
				next_cycle();
			end
		end
		trim_i = 1'b0;
		for (int c = 0; c < 40; c++) begin
			hblank_i = rand_bits(1);
			#1;
			check_value("hblank_o", hblank_i, hblank_o);
			next_cycle();
		end
		end_test("overscan trim");

		if (u_dut.u_asserts.fail_count != 0)
			report_failure("bound assertions failed during the run");
		$display("%0d of 6 tests ok, %0d checks, %0d errors", tests_ok, checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- vp_host_glue.f
+incdir+design
design/vp_pkg.sv
design/vp_clock_enables.sv
design/vp_input_router.sv
design/vp_key_translate.sv
design/vp_rom_port.sv
design/vp_av_encode.sv
design/vp_host_glue.sv
testbench/vp_host_glue_asserts.sv
testbench/tb_vp_host_glue.sv
